// File: verification/chain_testdata.txt
// hex words: sck_div, chip_num, gap, then the two blocks of eight words,
// then two replies per chip and block, then the expected nonce per chip and block
02
3
14
// block 0, nonce at word 4
01234567 89abcdef deadbeef 00000000 ff001234 ffffffff 13579bdf 2468ace0
// block 1
0f0f0f0f f0f0f0f0 cafef00d 55aa55aa a5a55a5a 00000001 80000000 7e7e7e7e
// replies of block 0, chips 0 to 2
0a000001 8a000002
0b000003 8b000004
0c000005 8c000006
// replies of block 1, chips 0 to 2
1a0000f1 9a0000f2
1b0000f3 9b0000f4
1c0000f5 9c0000f6
// nonce seen by chips 0 to 2, block 0 then block 1
ff001234 00011234 01011234
a5a55a5a a6a55a5a a7a55a5a

// File: filelist.f
design/chain_cfg_pkg.sv
design/chain_types_pkg.sv
design/work_buffer.sv
design/serial_phy.sv
design/chain_sequencer.sv
design/chain_top.sv
verification/chain_properties.sv
verification/chain_tb.sv

// File: Makefile
TOP = chain_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: verification/chain_tb.sv
module chain_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WL  = chain_cfg_pkg::WORK_LEN;
	localparam int RW  = chain_cfg_pkg::RESULT_WORDS;
	localparam int NCH = chain_cfg_pkg::MAX_CHIPS;
	// both file blocks go out twice, so the work buffer runs full
	localparam int FILE_BLOCKS  = 2;
	localparam int TOTAL_BLOCKS = 2 * FILE_BLOCKS;
	// data file layout: three config words, then blocks, replies, nonces
	localparam int BLK_BASE   = 3;
	localparam int REPLY_BASE = BLK_BASE + FILE_BLOCKS * WL;

	logic                        clk;
	logic                        rst;
	chain_types_pkg::link_cfg_t  cfg;
	logic                        busy;
	logic                        work_valid;
	logic                        work_ready;
	chain_types_pkg::work_word_t work_data;
	logic                        res_valid;
	logic                        res_ready = 1'b0;
	chain_types_pkg::result_t    res_data;
	logic                        sck;
	logic                        mosi;
	logic                        miso;
	logic [NCH-1:0]              load;
	logic [NCH-1:0]              chip_out;

	logic [31:0] td [64];
	int          chips;
	int          mismatches;
	int          failures;
	int          cap_bits;
	int          cap_word;
	int          cap_chip;
	int          cap_blk;
	logic [31:0] cap_sr;
	bit   [7:0]  fall_cnt;
	int          res_cnt;
	int          busy_falls;
	bit          busy_q;
	bit          saw_full;
	int          ready_phase;

	chain_top i_dut (.*);

	function automatic int block_addr(input int b, input int w);
		return BLK_BASE + b * WL + w;
	endfunction

	function automatic int reply_addr(input int b, input int c, input int r);
		return REPLY_BASE + (b * chips + c) * RW + r;
	endfunction

	function automatic int nonce_addr(input int b, input int c);
		return REPLY_BASE + FILE_BLOCKS * chips * RW + b * chips + c;
	endfunction

	// reply bit of chip c; fall_cnt wraps after the eight words of one chip
	function automatic logic reply_bit(input int c);
		logic [31:0] w;
		int          r;
		r = int'(fall_cnt[7:5]);
		w = 32'hFFFF_FFFF;
		if (r < RW && c < chips)
			w = td[reply_addr(cap_blk % FILE_BLOCKS, c, r)];
		return w[31 - int'(fall_cnt[4:0])];
	endfunction

	task automatic show_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		$display("mismatch at %0t: %s expected %h, seen %h", $time, name, exp, got);
		mismatches++;
	endtask

	task automatic record_failure(input string what);
		$display("error at %0t: %s", $time, what);
		failures++;
	endtask

	task automatic print_summary();
		$display("summary: %0d mismatches, %0d other errors", mismatches, failures);
	endtask

	task automatic run_watchdog();
		longint limit;
		limit = longint'(TOTAL_BLOCKS) * chips * (WL * (64 * cfg.sck_div + 8) + 240)
			+ TOTAL_BLOCKS * (cfg.gap + 50) + 2000;
		#(limit * 10);
		$display("timeout: run did not finish within %0d cycles", limit);
		print_summary();
		$display("Checks failed");
		$finish;
	endtask

	// host side, one word per accepted transfer
	task automatic feed_blocks();
		for (int n = 0; n < TOTAL_BLOCKS; n++) begin
			for (int w = 0; w < WL; w++) begin
				work_valid     <= 1'b1;
				work_data.last <= (w == WL - 1);
				work_data.data <= td[block_addr(n % FILE_BLOCKS, w)];
				@(negedge clk);
				while (!work_ready)
					@(negedge clk);
				@(posedge clk);
			end
		end
		work_valid <= 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// unselected chips hold their output high, the line is a wired AND
	always_comb begin
		for (int c = 0; c < NCH; c++)
			chip_out[c] = load[c] | reply_bit(c);
	end
	assign miso = &chip_out;

	always @(negedge sck) begin
		if (!rst)
			fall_cnt <= fall_cnt + 8'd1;
	end

	// chip side capture of mosi, one word per 32 rising edges
	always @(posedge sck) begin
		logic [31:0]    word;
		logic [31:0]    exp;
		logic [NCH-1:0] exp_load;
		int             b;
		if (!rst) begin
			word     = {cap_sr[30:0], mosi};
			exp_load = ~(NCH'(1) << cap_chip);
			cap_sr  <= word;
			assert (load == exp_load)
				else show_mismatch("load", 32'(exp_load), 32'(load));
			if (cap_bits == 31) begin
				b   = cap_blk % FILE_BLOCKS;
				exp = (cap_word == chain_cfg_pkg::NONCE_IDX) ? td[nonce_addr(b, cap_chip)]
					: td[block_addr(b, cap_word)];
				assert (word == exp)
					else show_mismatch($sformatf("mosi word %0d chip %0d", cap_word, cap_chip),
						exp, word);
				cap_bits <= 0;
				if (cap_word == WL - 1) begin
					cap_word <= 0;
					if (cap_chip == chips - 1) begin
						cap_chip <= 0;
						cap_blk  <= cap_blk + 1;
					end else begin
						cap_chip <= cap_chip + 1;
					end
				end else begin
					cap_word <= cap_word + 1;
				end
			end else begin
				cap_bits <= cap_bits + 1;
			end
		end
	end

	// slow result sink
	always @(posedge clk) begin
		if (rst) begin
			ready_phase <= 0;
			res_ready   <= 1'b0;
		end else begin
			ready_phase <= (ready_phase == 239) ? 0 : ready_phase + 1;
			res_ready   <= (ready_phase < 40);
		end
	end

	// handshakes are sampled mid cycle, the transfer happens on the next edge
	always @(negedge clk) begin
		int          k;
		int          c;
		logic [31:0] exp;
		k = res_cnt;
		busy_q <= busy;
		if (!rst) begin
			if (work_valid && !work_ready && cap_blk == 0)
				saw_full <= 1'b1;
			if (!busy)
				assert (load == '1)
					else show_mismatch("load while idle", 32'({NCH{1'b1}}), 32'(load));
			if (busy_q && !busy) begin
				assert (cap_blk == busy_falls + 1)
					else record_failure("busy fell before the last chip of a block was served");
				busy_falls <= busy_falls + 1;
			end
			if (res_valid && res_ready) begin
				c   = (k / RW) % chips;
				exp = td[reply_addr((k / (RW * chips)) % FILE_BLOCKS, c, k % RW)];
				assert (int'(res_data.chip) == c)
					else show_mismatch("res_data.chip", 32'(c), 32'(res_data.chip));
				assert (res_data.data == exp)
					else show_mismatch("res_data.data", exp, res_data.data);
				res_cnt <= k + 1;
			end
		end
	end

	initial begin
		rst        = 1'b1;
		work_valid = 1'b0;
		work_data  = '0;
		cfg        = '0;
		for (int i = 0; i < 64; i++)
			td[i] = '0;
		$readmemh("verification/chain_testdata.txt", td);
		cfg.sck_div  = td[0][7:0];
		cfg.chip_num = td[1][3:0];
		cfg.gap      = td[2][10:0];
		chips        = int'(cfg.chip_num);
		fork
			run_watchdog();
		join_none
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!busy && load == '1 && !res_valid && work_ready)
			else record_failure("outputs are not idle after reset");
		@(posedge clk);
		feed_blocks();
		while (cap_blk != TOTAL_BLOCKS || res_cnt != TOTAL_BLOCKS * chips * RW || busy)
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (saw_full)
			else record_failure("work_ready never fell while the work buffer was full");
		assert (busy_falls == TOTAL_BLOCKS)
			else record_failure("busy did not fall once per block");
		assert (i_dut.i_props.fail_cnt == 0)
			else record_failure("a bound property failed");
		print_summary();
		if (mismatches == 0 && failures == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: verification/chain_properties.sv
module chain_properties (
	input logic                                clk,
	input logic                                rst,
	input logic [chain_cfg_pkg::MAX_CHIPS-1:0] load,
	input logic                                sck,
	input logic                                tx_ready,
	input logic                                res_valid,
	input logic                                res_ready,
	input chain_types_pkg::result_t            res_data
);
	timeunit 1ns;
	timeprecision 100ps;

	// assertion failures counted so far
	int fail_cnt = 0;

	// chips share miso so at most one is selected and exactly one while a word shifts
	one_chip_selected: assert property (@(posedge clk) disable iff (rst)
		tx_ready ? $onehot0(~load) : $onehot(~load))
		else begin
			$error("wrong load lines %b with tx_ready %b", load, tx_ready);
			fail_cnt++;
		end

	sck_idle_low: assert property (@(posedge clk) disable iff (rst) tx_ready |-> !sck)
		else begin
			$error("sck high while the phy is idle");
			fail_cnt++;
		end

	result_held: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_ready |=> res_valid && $stable(res_data))
		else begin
			$error("result changed before it was accepted");
			fail_cnt++;
		end

endmodule

bind chain_top chain_properties i_props (
	.clk       (clk),
	.rst       (rst),
	.load      (load),
	.sck       (sck),
	.tx_ready  (tx_ready),
	.res_valid (sq_res_valid),
	.res_ready (sq_res_ready),
	.res_data  (sq_res_data)
);

// File: design/chain_top.sv
module chain_top (
	input  logic                                clk,
	input  logic                                rst,
	input  chain_types_pkg::link_cfg_t          cfg,
	output logic                                busy,
	input  logic                                work_valid,
	output logic                                work_ready,
	input  chain_types_pkg::work_word_t         work_data,
	output logic                                res_valid,
	input  logic                                res_ready,
	output chain_types_pkg::result_t            res_data,
	output logic                                sck,
	output logic                                mosi,
	input  logic                                miso,
	output logic [chain_cfg_pkg::MAX_CHIPS-1:0] load
);

	// buffered work toward the sequencer
	logic                                wb_valid;
	logic                                wb_ready;
	chain_types_pkg::work_word_t         wb_data;

	// sequencer to phy
	logic                                tx_valid;
	logic                                tx_ready;
	logic [chain_cfg_pkg::WORD_W-1:0]    tx_data;
	logic                                rx_valid;
	logic [chain_cfg_pkg::WORD_W-1:0]    rx_data;

	// sequencer to result queue
	logic                                sq_res_valid;
	logic                                sq_res_ready;
	chain_types_pkg::result_t            sq_res_data;
	logic [chain_cfg_pkg::RES_CNT_W-1:0] res_free;

	work_buffer #(
		.DEPTH  (chain_cfg_pkg::BUF_DEPTH),
		.data_t (chain_types_pkg::work_word_t)
	) i_work_buf (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (work_valid),
		.in_ready  (work_ready),
		.in_data   (work_data),
		.out_valid (wb_valid),
		.out_ready (wb_ready),
		.out_data  (wb_data),
		.free      ()
	);

	chain_sequencer i_seq (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.busy       (busy),
		.work_valid (wb_valid),
		.work_ready (wb_ready),
		.work_data  (wb_data),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.tx_data    (tx_data),
		.rx_valid   (rx_valid),
		.rx_data    (rx_data),
		.res_valid  (sq_res_valid),
		.res_ready  (sq_res_ready),
		.res_data   (sq_res_data),
		.res_free   (res_free),
		.load       (load)
	);

	serial_phy i_phy (
		.clk      (clk),
		.rst      (rst),
		.sck_div  (cfg.sck_div),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_data  (tx_data),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.sck      (sck),
		.mosi     (mosi),
		.miso     (miso)
	);

	work_buffer #(
		.DEPTH  (chain_cfg_pkg::RES_DEPTH),
		.data_t (chain_types_pkg::result_t)
	) i_res_buf (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (sq_res_valid),
		.in_ready  (sq_res_ready),
		.in_data   (sq_res_data),
		.out_valid (res_valid),
		.out_ready (res_ready),
		.out_data  (res_data),
		.free      (res_free)
	);

endmodule

// File: design/chain_sequencer.sv
module chain_sequencer (
	input  logic                                  clk,
	input  logic                                  rst,
	input  chain_types_pkg::link_cfg_t            cfg,
	output logic                                  busy,
	input  logic                                  work_valid,
	output logic                                  work_ready,
	input  chain_types_pkg::work_word_t           work_data,
	output logic                                  tx_valid,
	input  logic                                  tx_ready,
	output logic [chain_cfg_pkg::WORD_W-1:0]      tx_data,
	input  logic                                  rx_valid,
	input  logic [chain_cfg_pkg::WORD_W-1:0]      rx_data,
	output logic                                  res_valid,
	input  logic                                  res_ready,
	output chain_types_pkg::result_t              res_data,
	input  logic [chain_cfg_pkg::RES_CNT_W-1:0]   res_free,
	output logic [chain_cfg_pkg::MAX_CHIPS-1:0]   load
);

	chain_types_pkg::seq_state_t                  state;
	logic [chain_cfg_pkg::WORD_W-1:0]             blk [chain_cfg_pkg::WORK_LEN];
	logic [$clog2(chain_cfg_pkg::WORK_LEN)-1:0]   word_cnt;
	logic [chain_cfg_pkg::CHIP_W-1:0]             chip;
	logic                                         in_flight;
	logic [10:0]                                  gap_cnt;
	logic                                         fill_acc;
	logic                                         tx_acc;
	logic                                         last_word;
	logic                                         last_chip;
	logic                                         start_ok;
	logic                                         keep_reply;
	logic [chain_cfg_pkg::WORD_W-1:0]             nonce_word;

	function automatic logic [31:0] bswap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign busy       = (state != chain_types_pkg::IDLE);
	assign work_ready = (state == chain_types_pkg::FILL);
	assign fill_acc   = work_valid && work_ready;
	assign tx_acc     = tx_valid && tx_ready;
	assign last_word  = (word_cnt == ($bits(word_cnt))'(chain_cfg_pkg::WORK_LEN - 1));
	assign last_chip  = (4'(chip) + 4'd1 == cfg.chip_num);
	assign keep_reply = (word_cnt < ($bits(word_cnt))'(chain_cfg_pkg::RESULT_WORDS));

	// room for every result of a chip, including one still held here
	assign start_ok = (res_free >= chain_cfg_pkg::RES_CNT_W'(chain_cfg_pkg::RESULT_WORDS))
		&& !res_valid;

	// nonce is little endian on the chip side
	assign nonce_word = bswap(bswap(blk[chain_cfg_pkg::NONCE_IDX])
		+ chain_cfg_pkg::WORD_W'(chip));

	assign tx_data  = (word_cnt == chain_cfg_pkg::NONCE_IDX) ? nonce_word : blk[word_cnt];
	assign tx_valid = (state == chain_types_pkg::SEND) && !in_flight
		&& (word_cnt != '0 || start_ok);

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= chain_types_pkg::IDLE;
			word_cnt  <= '0;
			chip      <= '0;
			in_flight <= 1'b0;
			gap_cnt   <= '0;
			load      <= '1;
		end else begin
			case (state)
				chain_types_pkg::IDLE: begin
					if (work_valid && cfg.chip_num != 4'd0) begin
						state    <= chain_types_pkg::FILL;
						word_cnt <= '0;
					end
				end
				chain_types_pkg::FILL: begin
					if (fill_acc) begin
						word_cnt <= word_cnt + 1'b1;
						if (work_data.last) begin
							state    <= chain_types_pkg::SEND;
							word_cnt <= '0;
							chip     <= '0;
						end
					end
				end
				chain_types_pkg::SEND: begin
					if (tx_acc) begin
						in_flight <= 1'b1;
						// select the chip together with its first word
						if (word_cnt == '0)
							load <= ~(chain_cfg_pkg::MAX_CHIPS'(1) << chip);
					end
					if (rx_valid) begin
						in_flight <= 1'b0;
						if (last_word) begin
							word_cnt <= '0;
							state    <= chain_types_pkg::NEXT;
						end else begin
							word_cnt <= word_cnt + 1'b1;
						end
					end
				end
				chain_types_pkg::NEXT: begin
					load <= '1;
					if (last_chip) begin
						state   <= chain_types_pkg::GAP;
						gap_cnt <= cfg.gap;
						chip    <= '0;
					end else begin
						state <= chain_types_pkg::SEND;
						chip  <= chip + 1'b1;
					end
				end
				chain_types_pkg::GAP: begin
					if (gap_cnt == '0)
						state <= chain_types_pkg::IDLE;
					else
						gap_cnt <= gap_cnt - 11'd1;
				end
				default: state <= chain_types_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_acc)
			blk[word_cnt] <= work_data.data;
	end

	// result holding register, first replies of each chip only
	always_ff @(posedge clk) begin
		if (rst)
			res_valid <= 1'b0;
		else if (state == chain_types_pkg::SEND && rx_valid && keep_reply)
			res_valid <= 1'b1;
		else if (res_ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (state == chain_types_pkg::SEND && rx_valid && keep_reply) begin
			res_data.chip <= chip;
			res_data.data <= rx_data;
		end
	end

endmodule

// File: design/serial_phy.sv
module serial_phy (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  sck_div,
	input  logic        tx_valid,
	output logic        tx_ready,
	input  logic [31:0] tx_data,
	output logic        rx_valid,
	output logic [31:0] rx_data,
	output logic        sck,
	output logic        mosi,
	input  logic        miso
);

	logic        busy;
	logic        ending;
	logic [7:0]  div_cnt;
	logic [4:0]  bit_cnt;
	logic [31:0] shreg;
	logic        tick;
	logic        start;

	assign tx_ready = !busy;
	assign start    = tx_valid && tx_ready;
	assign rx_data  = shreg;

	// one sck half period has elapsed
	assign tick = busy && !ending && (div_cnt == sck_div - 8'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			ending   <= 1'b0;
			rx_valid <= 1'b0;
			sck      <= 1'b0;
			mosi     <= 1'b0;
			div_cnt  <= '0;
			bit_cnt  <= '0;
		end else begin
			rx_valid <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				// msb is on the line before the first rising edge
				mosi    <= tx_data[31];
			end else if (ending) begin
				ending   <= 1'b0;
				busy     <= 1'b0;
				rx_valid <= 1'b1;
			end else if (busy) begin
				if (tick) begin
					div_cnt <= '0;
					sck     <= !sck;
					// falling edge, move on to the next bit
					if (sck) begin
						bit_cnt <= bit_cnt + 5'd1;
						if (bit_cnt == 5'd31) begin
							ending <= 1'b1;
							mosi   <= 1'b0;
						end else begin
							mosi <= shreg[31];
						end
					end
				end else begin
					div_cnt <= div_cnt + 8'd1;
				end
			end
		end
	end

	// tx bits leave at the top while miso bits enter at the bottom
	always_ff @(posedge clk) begin
		if (start)
			shreg <= tx_data;
		else if (tick && !sck)
			shreg <= {shreg[30:0], miso};
	end

endmodule

// File: design/work_buffer.sv
module work_buffer #(
	parameter int  DEPTH  = chain_cfg_pkg::BUF_DEPTH,
	parameter type data_t = chain_types_pkg::work_word_t
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  data_t                      in_data,
	output logic                       out_valid,
	input  logic                       out_ready,
	output data_t                      out_data,
	output logic [$clog2(DEPTH+1)-1:0] free
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	data_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wrap at DEPTH so sizes that are not a power of two also work
	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];
	assign free      = CNT_W'(DEPTH) - count;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= bump(wr_ptr);
			if (pop)
				rd_ptr <= bump(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

// File: design/chain_types_pkg.sv
package chain_types_pkg;

	// host word, last is set on the final word of a block
	typedef struct packed {
		logic                             last;
		logic [chain_cfg_pkg::WORD_W-1:0] data;
	} work_word_t;

	// reply word tagged with the chip it came from
	typedef struct packed {
		logic [chain_cfg_pkg::CHIP_W-1:0] chip;
		logic [chain_cfg_pkg::WORD_W-1:0] data;
	} result_t;

	typedef struct packed {
		// clock cycles per sck half period, at least 1
		logic [7:0]  sck_div;
		// chips in the chain
		logic [3:0]  chip_num;
		// idle cycles after a block
		logic [10:0] gap;
	} link_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		FILL,
		SEND,
		NEXT,
		GAP
	} seq_state_t;

endpackage

// File: design/chain_cfg_pkg.sv
package chain_cfg_pkg;

	// words in one work block
	localparam int WORK_LEN = 8;
	// position of the nonce inside the block
	localparam int NONCE_IDX = 4;
	// reply words kept from each chip
	localparam int RESULT_WORDS = 2;
	// load lines, also the longest chain
	localparam int MAX_CHIPS = 8;

	localparam int WORD_W = 32;
	localparam int CHIP_W = $clog2(MAX_CHIPS);

	// work buffer entries
	localparam int BUF_DEPTH = 16;
	// result queue is kept short so a slow sink stalls the chain early
	localparam int RES_DEPTH = 4;
	localparam int RES_CNT_W = $clog2(RES_DEPTH + 1);

endpackage
